// File: hdl/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// fixed sizes of the back end

// data and address word width in bits
`define XLEN        32

// general registers x0..x31
`define REG_COUNT   32

// data memory depth in words (1 KiB)
`define DMEM_WORDS  256

`endif

// File: hdl/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

`include "cpu_params.svh"

// one data or address word
typedef logic [`XLEN-1:0] word_t;

// general register index
typedef logic [$clog2(`REG_COUNT)-1:0] regaddr_t;

// access size, encoded like funct3 of loads and stores
typedef enum logic [2:0] {
    MA_SIZE_B  = 3'd0,
    MA_SIZE_H  = 3'd1,
    MA_SIZE_W  = 3'd2,
    MA_SIZE_BU = 3'd4,
    MA_SIZE_HU = 3'd5
} ma_size_t;

// what the back end does with an operation
typedef enum logic [1:0] {
    OP_REG,     // write alu result to rd
    OP_LOAD,    // write memory data to rd
    OP_STORE    // write memory, no rd
} op_kind_t;

// pc carried by an empty stage slot
localparam word_t NOP_PC = 32'hffff_fffc;

endpackage

`default_nettype wire

// File: hdl/cpu_ma.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_ma
    import cpu_pkg::*;
(
    input  wire logic       clk_i,
    input  wire logic       reset_i,

    input  wire logic       issue_valid_i,
    output      logic       issue_ready_o,
    input  wire word_t      issue_pc_i,
    input  wire word_t      issue_ir_i,
    input  wire word_t      issue_result_i,     // alu result or address
    input  wire word_t      issue_store_data_i,

    input  wire logic       wb_ready_i,
    output      logic       ma_valid_o,
    output      word_t      ma_pc_o,
    output      word_t      ma_ir_o,
    output      word_t      ma_data_o,
    output      op_kind_t   ma_kind_o,
    output      ma_size_t   ma_size_o,
    output      logic [1:0] ma_alignment_o,

    output      logic       dmem_en_o,
    output      logic       dmem_we_o,
    output      word_t      dmem_addr_o,        // word address
    output      logic [3:0] dmem_be_o,
    output      word_t      dmem_wdata_o
);

// major opcodes that touch memory
typedef enum logic [6:0] {
    OPC_LOAD  = 7'b0000011,
    OPC_STORE = 7'b0100011
} opcode_t;

op_kind_t issue_kind;
ma_size_t issue_size;

logic     valid_q;
word_t    pc_q;
word_t    ir_q;
word_t    result_q;
word_t    store_q;
op_kind_t kind_q;
ma_size_t size_q;

logic     advance;

always_comb begin
    case (issue_ir_i[6:0])
        OPC_LOAD:  issue_kind = OP_LOAD;
        OPC_STORE: issue_kind = OP_STORE;
        default:   issue_kind = OP_REG;
    endcase

    // register writes pass the whole word through
    if (issue_kind == OP_REG) begin
        issue_size = MA_SIZE_W;
    end else begin
        issue_size = ma_size_t'(issue_ir_i[14:12]);
    end
end

assign advance       = valid_q && wb_ready_i;
assign issue_ready_o = !valid_q || advance;    // empty or moving on

always_ff @(posedge clk_i) begin
    if (reset_i) begin
        valid_q <= 1'b0;
        pc_q    <= NOP_PC;
    end else if (issue_ready_o) begin
        valid_q <= issue_valid_i;
        pc_q    <= issue_valid_i ? issue_pc_i : NOP_PC;
    end
end

always_ff @(posedge clk_i) begin
    if (issue_ready_o && issue_valid_i) begin
        ir_q     <= issue_ir_i;
        result_q <= issue_result_i;
        store_q  <= issue_store_data_i;
        kind_q   <= issue_kind;
        size_q   <= issue_size;
    end
end

assign ma_valid_o     = valid_q;
assign ma_pc_o        = pc_q;
assign ma_ir_o        = ir_q;
assign ma_data_o      = result_q;
assign ma_kind_o      = kind_q;
assign ma_size_o      = size_q;
assign ma_alignment_o = (kind_q == OP_LOAD) ? result_q[1:0] : 2'b00;

// memory access happens on the advance edge
assign dmem_en_o    = advance;
assign dmem_we_o    = valid_q && (kind_q == OP_STORE);
assign dmem_addr_o  = {2'b00, result_q[31:2]};
assign dmem_wdata_o = store_q << {result_q[1:0], 3'b000};   // move to byte lane

always_comb begin
    case (size_q)
        MA_SIZE_B, MA_SIZE_BU: dmem_be_o = 4'b0001 << result_q[1:0];
        MA_SIZE_H, MA_SIZE_HU: dmem_be_o = 4'b0011 << result_q[1:0];
        default:               dmem_be_o = 4'b1111;
    endcase
end

endmodule

`default_nettype wire

// File: hdl/cpu_dmem.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module cpu_dmem
    import cpu_pkg::*;
(
    input  wire logic       clk_i,
    input  wire logic       en_i,
    input  wire logic       we_i,
    input  wire word_t      addr_i,     // word address
    input  wire logic [3:0] be_i,
    input  wire word_t      wdata_i,
    output      word_t      rdata_o
);

localparam int AW = $clog2(`DMEM_WORDS);

word_t mem [0:`DMEM_WORDS-1];
word_t rdata_q;

always_ff @(posedge clk_i) begin
    if (en_i) begin
        if (we_i) begin
            for (int i = 0; i < 4; i++) begin
                if (be_i[i]) begin
                    mem[addr_i[AW-1:0]][8*i +: 8] <= wdata_i[8*i +: 8];
                end
            end
        end
        rdata_q <= mem[addr_i[AW-1:0]];     // old word, held while idle
    end
end

assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// File: hdl/cpu_wb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_wb
    import cpu_pkg::*;
(
    input  wire logic       clk_i,
    input  wire logic       reset_i,

    input  wire word_t      dmem_read_data_i,

    input  wire logic       ma_valid_i,
    output      logic       wb_ready_o,
    input  wire word_t      ma_pc_i,
    input  wire word_t      ma_ir_i,
    input  wire word_t      ma_data_i,
    input  wire op_kind_t   ma_kind_i,
    input  wire ma_size_t   ma_size_i,
    input  wire logic [1:0] ma_alignment_i,

    output      logic       retire_valid_o,
    input  wire logic       retire_ready_i,
    output      word_t      retire_pc_o,
    output      regaddr_t   retire_rd_o,
    output      word_t      retire_data_o,
    output      logic       retire_we_o,
    output      logic       empty_o
);

logic       valid_q;
word_t      pc_q;
word_t      ir_q;
word_t      data_q;
op_kind_t   kind_q;
ma_size_t   size_q;
logic [1:0] align_q;

logic       transfer;
word_t      unaligned;
word_t      aligned;
word_t      extended;

assign wb_ready_o = !valid_q || retire_ready_i;
assign transfer   = ma_valid_i && wb_ready_o;

always_ff @(posedge clk_i) begin
    if (reset_i) begin
        valid_q <= 1'b0;
        pc_q    <= NOP_PC;
    end else if (wb_ready_o) begin
        valid_q <= ma_valid_i;
        pc_q    <= ma_pc_i;     // NOP_PC when ma is empty
    end
end

always_ff @(posedge clk_i) begin
    if (transfer) begin
        ir_q    <= ma_ir_i;
        data_q  <= ma_data_i;
        kind_q  <= ma_kind_i;
        size_q  <= ma_size_i;
        align_q <= ma_alignment_i;
    end
end

always_comb begin
    unaligned = (kind_q == OP_LOAD) ? dmem_read_data_i : data_q;

    // bring the addressed byte down to bit 0
    case (align_q)
        2'b00:   aligned = unaligned;
        2'b01:   aligned = {8'b0, unaligned[31:8]};
        2'b10:   aligned = {16'b0, unaligned[31:16]};
        default: aligned = {24'b0, unaligned[31:24]};
    endcase

    case (size_q)
        MA_SIZE_B:  extended = {{24{aligned[7]}}, aligned[7:0]};
        MA_SIZE_H:  extended = {{16{aligned[15]}}, aligned[15:0]};
        MA_SIZE_BU: extended = {24'b0, aligned[7:0]};
        MA_SIZE_HU: extended = {16'b0, aligned[15:0]};
        default:    extended = aligned;     // full word
    endcase
end

assign retire_valid_o = valid_q;
assign retire_pc_o    = pc_q;
assign retire_rd_o    = valid_q ? ir_q[11:7] : '0;
assign retire_data_o  = valid_q ? extended : '0;
assign retire_we_o    = valid_q && (kind_q != OP_STORE);   // stores write no rd

// nothing here and nothing coming from ma, never while in reset
assign empty_o = !reset_i && !valid_q && (ma_pc_i == NOP_PC);

endmodule

`default_nettype wire

// File: hdl/cpu_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module cpu_regfile
    import cpu_pkg::*;
(
    input  wire logic     clk_i,
    input  wire logic     reset_i,
    input  wire logic     we_i,
    input  wire regaddr_t waddr_i,
    input  wire word_t    wdata_i,
    input  wire regaddr_t raddr_i,
    output      word_t    rdata_o
);

word_t regs [0:`REG_COUNT-1];

always_ff @(posedge clk_i) begin
    if (reset_i) begin
        for (int i = 0; i < `REG_COUNT; i++) begin
            regs[i] <= '0;
        end
    end else if (we_i && (waddr_i != '0)) begin   // x0 stays zero
        regs[waddr_i] <= wdata_i;
    end
end

assign rdata_o = regs[raddr_i];

endmodule

`default_nettype wire

// File: hdl/cpu_mem_wb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_mem_wb
    import cpu_pkg::*;
(
    input  wire logic     clk_i,
    input  wire logic     reset_i,

    input  wire logic     issue_valid_i,
    output      logic     issue_ready_o,
    input  wire word_t    issue_pc_i,
    input  wire word_t    issue_ir_i,
    input  wire word_t    issue_result_i,
    input  wire word_t    issue_store_data_i,

    output      logic     retire_valid_o,
    input  wire logic     retire_ready_i,
    output      word_t    retire_pc_o,
    output      regaddr_t retire_rd_o,
    output      word_t    retire_data_o,
    output      logic     retire_we_o,

    input  wire regaddr_t rs_addr_i,
    output      word_t    rs_data_o,
    output      logic     empty_o
);

// ma to wb stage transfer
logic       wb_ready;
logic       ma_valid;
word_t      ma_pc;
word_t      ma_ir;
word_t      ma_data;
op_kind_t   ma_kind;
ma_size_t   ma_size;
logic [1:0] ma_alignment;

// data memory
logic       dmem_en;
logic       dmem_we;
word_t      dmem_addr;
logic [3:0] dmem_be;
word_t      dmem_wdata;
word_t      dmem_rdata;

cpu_ma cpu_ma_inst (
    .clk_i              (clk_i),
    .reset_i            (reset_i),
    .issue_valid_i      (issue_valid_i),
    .issue_ready_o      (issue_ready_o),
    .issue_pc_i         (issue_pc_i),
    .issue_ir_i         (issue_ir_i),
    .issue_result_i     (issue_result_i),
    .issue_store_data_i (issue_store_data_i),
    .wb_ready_i         (wb_ready),
    .ma_valid_o         (ma_valid),
    .ma_pc_o            (ma_pc),
    .ma_ir_o            (ma_ir),
    .ma_data_o          (ma_data),
    .ma_kind_o          (ma_kind),
    .ma_size_o          (ma_size),
    .ma_alignment_o     (ma_alignment),
    .dmem_en_o          (dmem_en),
    .dmem_we_o          (dmem_we),
    .dmem_addr_o        (dmem_addr),
    .dmem_be_o          (dmem_be),
    .dmem_wdata_o       (dmem_wdata)
);

cpu_dmem cpu_dmem_inst (
    .clk_i   (clk_i),
    .en_i    (dmem_en),
    .we_i    (dmem_we),
    .addr_i  (dmem_addr),
    .be_i    (dmem_be),
    .wdata_i (dmem_wdata),
    .rdata_o (dmem_rdata)
);

cpu_wb cpu_wb_inst (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .dmem_read_data_i (dmem_rdata),
    .ma_valid_i       (ma_valid),
    .wb_ready_o       (wb_ready),
    .ma_pc_i          (ma_pc),
    .ma_ir_i          (ma_ir),
    .ma_data_i        (ma_data),
    .ma_kind_i        (ma_kind),
    .ma_size_i        (ma_size),
    .ma_alignment_i   (ma_alignment),
    .retire_valid_o   (retire_valid_o),
    .retire_ready_i   (retire_ready_i),
    .retire_pc_o      (retire_pc_o),
    .retire_rd_o      (retire_rd_o),
    .retire_data_o    (retire_data_o),
    .retire_we_o      (retire_we_o),
    .empty_o          (empty_o)
);

// write only on a completed retire that carries rd
cpu_regfile cpu_regfile_inst (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .we_i    (retire_valid_o && retire_ready_i && retire_we_o),
    .waddr_i (retire_rd_o),
    .wdata_i (retire_data_o),
    .raddr_i (rs_addr_i),
    .rdata_o (rs_data_o)
);

endmodule

`default_nettype wire

// File: bench/cpu_mem_wb_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module cpu_mem_wb_tb
    import cpu_pkg::*;
();

localparam int    CLK_PERIOD   = 40;
localparam int    RESET_CYCLES = 16;
localparam word_t REGION_BASE  = 32'h0000_0200;   // 16 words of test data
localparam int    REGION_WORDS = 16;
localparam int    NUM_RANDOM   = 200;
localparam int    NUM_OPS      = `REG_COUNT + REGION_WORDS + 2 * 13 + NUM_RANDOM;
localparam int    TIMEOUT_NS   = (NUM_OPS * 40 + RESET_CYCLES) * CLK_PERIOD;

// expected retire record
typedef struct packed {
    word_t       pc;
    regaddr_t    rd;
    word_t       data;
    logic        we;
    logic [31:0] cycle;     // acceptance edge
} retire_rec_t;

logic     clk_i = 1'b0;
logic     reset_i;
logic     issue_valid_i;
logic     issue_ready_o;
word_t    issue_pc_i;
word_t    issue_ir_i;
word_t    issue_result_i;
word_t    issue_store_data_i;
logic     retire_valid_o;
logic     retire_ready_i;
word_t    retire_pc_o;
regaddr_t retire_rd_o;
word_t    retire_data_o;
logic     retire_we_o;
regaddr_t rs_addr_i;
word_t    rs_data_o;
logic     empty_o;

word_t       regs_model [0:`REG_COUNT-1];
logic [7:0]  mem_model [0:4*`DMEM_WORDS-1];    // byte addressed
retire_rec_t exp_q [$];
logic        ready_pattern [0:1023];
logic        random_ready;
int          seed;
word_t       next_pc;
int unsigned cycle = 0;
int unsigned last_stall = 0;    // last edge with retire_ready_i low
int          value_errors = 0;
int          protocol_errors = 0;
int          accepted = 0;
int          retired = 0;

cpu_mem_wb cpu_mem_wb_inst (
    .clk_i              (clk_i),
    .reset_i            (reset_i),
    .issue_valid_i      (issue_valid_i),
    .issue_ready_o      (issue_ready_o),
    .issue_pc_i         (issue_pc_i),
    .issue_ir_i         (issue_ir_i),
    .issue_result_i     (issue_result_i),
    .issue_store_data_i (issue_store_data_i),
    .retire_valid_o     (retire_valid_o),
    .retire_ready_i     (retire_ready_i),
    .retire_pc_o        (retire_pc_o),
    .retire_rd_o        (retire_rd_o),
    .retire_data_o      (retire_data_o),
    .retire_we_o        (retire_we_o),
    .rs_addr_i          (rs_addr_i),
    .rs_data_o          (rs_data_o),
    .empty_o            (empty_o)
);

always #(CLK_PERIOD / 2) clk_i = ~clk_i;

always @(posedge clk_i) cycle <= cycle + 1;

always @(posedge clk_i) begin
    retire_ready_i <= random_ready ? ready_pattern[cycle[9:0]] : 1'b1;
end

task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
        value_errors++;
        $display("[FAIL] %0d ns %s: got %h, expected %h", $time, name, got, exp);
    end
endtask

task automatic check_reg(input string name, input regaddr_t got, input regaddr_t exp);
    if (got !== exp) begin
        value_errors++;
        $display("[FAIL] %0d ns %s: got x%0d, expected x%0d", $time, name, got, exp);
    end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        value_errors++;
        $display("[FAIL] %0d ns %s: got %b, expected %b", $time, name, got, exp);
    end
endtask

// riscv encodings with rs1 and rs2 fields at zero
function automatic word_t reg_ir(input regaddr_t rd, input logic [2:0] f3);
    return {12'h000, 5'd0, f3, rd, 7'b0010011};     // op-imm
endfunction

function automatic word_t load_ir(input regaddr_t rd, input ma_size_t sz);
    return {12'h000, 5'd0, sz, rd, 7'b0000011};
endfunction

function automatic word_t store_ir(input ma_size_t sz, input logic [4:0] imm);
    return {7'h00, 5'd0, 5'd0, sz, imm, 7'b0100011};
endfunction

function automatic ma_size_t load_size(input int k);
    case (k)
        0:       return MA_SIZE_B;
        1:       return MA_SIZE_H;
        2:       return MA_SIZE_W;
        3:       return MA_SIZE_BU;
        default: return MA_SIZE_HU;
    endcase
endfunction

// keep accesses naturally aligned
function automatic logic [1:0] lane_offset(input ma_size_t sz, input logic [1:0] raw);
    case (sz)
        MA_SIZE_B, MA_SIZE_BU: return raw;
        MA_SIZE_H, MA_SIZE_HU: return {raw[1], 1'b0};
        default:               return 2'b00;
    endcase
endfunction

// expected retire record, and the model state moves on by one operation
function automatic retire_rec_t model_retire(input word_t pc, input word_t ir,
                                             input word_t result, input word_t sdata);
    retire_rec_t rec;
    op_kind_t    kind;
    ma_size_t    size;
    logic [9:0]  a;
    logic [7:0]  b0, b1, b2, b3;

    a    = result[9:0];
    size = ma_size_t'(ir[14:12]);
    case (ir[6:0])
        7'b0000011: kind = OP_LOAD;
        7'b0100011: kind = OP_STORE;
        default:    kind = OP_REG;
    endcase
    b0 = mem_model[a];
    b1 = mem_model[a + 10'd1];
    b2 = mem_model[a + 10'd2];
    b3 = mem_model[a + 10'd3];

    rec.pc    = pc;
    rec.rd    = ir[11:7];
    rec.we    = (kind != OP_STORE);
    rec.data  = result;
    rec.cycle = '0;
    if (kind == OP_LOAD) begin
        case (size)
            MA_SIZE_B:  rec.data = {{24{b0[7]}}, b0};
            MA_SIZE_H:  rec.data = {{16{b1[7]}}, b1, b0};
            MA_SIZE_BU: rec.data = {24'h0, b0};
            MA_SIZE_HU: rec.data = {16'h0, b1, b0};
            default:    rec.data = {b3, b2, b1, b0};
        endcase
    end else if (kind == OP_STORE) begin
        mem_model[a] = sdata[7:0];
        if (size != MA_SIZE_B) begin
            mem_model[a + 10'd1] = sdata[15:8];
        end
        if (size == MA_SIZE_W) begin
            mem_model[a + 10'd2] = sdata[23:16];
            mem_model[a + 10'd3] = sdata[31:24];
        end
    end
    if (rec.we && rec.rd != '0) begin
        regs_model[rec.rd] = rec.data;
    end
    return rec;
endfunction

// retire first, then acceptance, all on sampled pre-edge values
always @(posedge clk_i) begin : scoreboard
    retire_rec_t rec;

    if (!reset_i) begin
        if (retire_valid_o && retire_ready_i) begin
            if (exp_q.size() == 0) begin
                protocol_errors++;
                $display("%0d ns: pc %h retired with no operation pending", $time, retire_pc_o);
            end else begin
                rec = exp_q.pop_front();
                retired++;
                check_word("retire_pc_o", retire_pc_o, rec.pc);
                check_reg("retire_rd_o", retire_rd_o, rec.rd);
                check_flag("retire_we_o", retire_we_o, rec.we);
                if (rec.we) begin   // store data is not defined
                    check_word("retire_data_o", retire_data_o, rec.data);
                end
                if (last_stall <= rec.cycle && cycle != rec.cycle + 32'd2) begin
                    protocol_errors++;
                    $display("%0d ns: pc %h retired %0d cycles after acceptance, not 2",
                             $time, rec.pc, cycle - rec.cycle);
                end
            end
        end
        if (!retire_ready_i) begin
            last_stall = cycle;
        end
        if (issue_valid_i && issue_ready_o) begin
            rec = model_retire(issue_pc_i, issue_ir_i, issue_result_i, issue_store_data_i);
            rec.cycle = cycle;
            exp_q.push_back(rec);
            accepted++;
        end
    end
end

// call at a rising edge, returns at the acceptance edge
task automatic issue_op(input word_t ir, input word_t result, input word_t sdata);
    issue_valid_i      <= 1'b1;
    issue_pc_i         <= next_pc;
    issue_ir_i         <= ir;
    issue_result_i     <= result;
    issue_store_data_i <= sdata;
    next_pc = next_pc + 32'd4;
    @(posedge clk_i);
    while (!issue_ready_o) @(posedge clk_i);
endtask

task automatic idle_cycles(input int n);
    issue_valid_i <= 1'b0;
    repeat (n) @(posedge clk_i);
endtask

task automatic read_reg(input regaddr_t idx, input word_t exp);
    @(posedge clk_i);
    rs_addr_i <= idx;
    @(negedge clk_i);   // combinational read has settled
    check_word($sformatf("rs_data_o x%0d", idx), rs_data_o, exp);
endtask

task automatic print_counts();
    $display("errors: %0d value, %0d protocol; operations: %0d accepted, %0d retired",
             value_errors, protocol_errors, accepted, retired);
endtask

initial begin : watchdog
    #(TIMEOUT_NS);
    $display("watchdog expired after %0d ns with %0d operations pending",
             TIMEOUT_NS, exp_q.size());
    print_counts();
    $display("Test failed");
    $finish;
end

initial begin : stimulus
    word_t    r;
    word_t    r2;
    word_t    addr;
    ma_size_t sz;

    seed    = 46;
    next_pc = 32'h0000_1000;
    reset_i            <= 1'b1;
    issue_valid_i      <= 1'b0;
    issue_pc_i         <= '0;
    issue_ir_i         <= '0;
    issue_result_i     <= '0;
    issue_store_data_i <= '0;
    retire_ready_i     <= 1'b0;
    rs_addr_i          <= '0;
    random_ready       <= 1'b0;
    for (int i = 0; i < `REG_COUNT; i++) begin
        regs_model[i] = '0;
    end
    for (int i = 0; i < 1024; i++) begin
        r = $random(seed);
        ready_pattern[i] = (r[1:0] != 2'b00);   // ready about 3 of 4 cycles
    end

    repeat (RESET_CYCLES - 1) @(posedge clk_i);
    @(negedge clk_i);
    check_flag("empty_o", empty_o, 1'b0);   // held low in reset
    @(posedge clk_i);
    reset_i <= 1'b0;
    @(negedge clk_i);
    check_flag("retire_valid_o", retire_valid_o, 1'b0);
    check_flag("retire_we_o", retire_we_o, 1'b0);
    check_flag("empty_o", empty_o, 1'b1);
    check_flag("issue_ready_o", issue_ready_o, 1'b1);
    check_reg("retire_rd_o", retire_rd_o, '0);
    check_word("retire_data_o", retire_data_o, '0);
    for (int i = 0; i < `REG_COUNT; i++) begin
        read_reg(regaddr_t'(i), '0);
    end
    @(posedge clk_i);

    // every rd once including x0
    for (int i = 0; i < `REG_COUNT; i++) begin
        r = $random(seed);
        issue_op(reg_ir(regaddr_t'(i), r[14:12]), r, '0);
    end

    // word stores fill the region, the first two words with mixed sign bits
    for (int w = 0; w < REGION_WORDS; w++) begin
        r = $random(seed);
        if (w == 0) begin
            r = 32'h80ff_017f;
        end else if (w == 1) begin
            r = 32'h7f00_fe81;
        end
        issue_op(store_ir(MA_SIZE_W, r[4:0]), REGION_BASE + 4 * w, r);
    end

    // every size at every aligned offset
    for (int w = 0; w < 2; w++) begin
        addr = REGION_BASE + 4 * w;
        for (int off = 0; off < 4; off++) begin
            r = $random(seed);
            issue_op(load_ir(r[11:7], MA_SIZE_B), addr + off, '0);
            issue_op(load_ir(r[16:12], MA_SIZE_BU), addr + off, '0);
        end
        for (int off = 0; off < 4; off += 2) begin
            r = $random(seed);
            issue_op(load_ir(r[11:7], MA_SIZE_H), addr + off, '0);
            issue_op(load_ir(r[16:12], MA_SIZE_HU), addr + off, '0);
        end
        r = $random(seed);
        issue_op(load_ir(r[11:7], MA_SIZE_W), addr, '0);
    end

    // random mix under back-pressure, with issue bubbles
    random_ready <= 1'b1;
    for (int n = 0; n < NUM_RANDOM; n++) begin
        r    = $random(seed);
        r2   = $random(seed);
        addr = REGION_BASE + {26'h0, r[7:4], 2'b00};
        if (r[9:8] == 2'b00) begin
            idle_cycles(r[10] ? 2 : 1);
        end
        case (r[3:2])
            2'b00, 2'b01: begin
                issue_op(reg_ir(r[20:16], r[23:21]), r2, '0);
            end
            2'b10: begin
                sz = load_size(int'(r[13:11]) % 5);
                issue_op(load_ir(r[20:16], sz), addr + {30'h0, lane_offset(sz, r[1:0])}, '0);
            end
            default: begin
                sz = ma_size_t'(int'(r[12:11]) % 3);   // sb, sh, sw
                issue_op(store_ir(sz, r[20:16]),
                         addr + {30'h0, lane_offset(sz, r[1:0])}, r2);
            end
        endcase
    end
    issue_valid_i <= 1'b0;

    do @(posedge clk_i); while (exp_q.size() != 0);
    @(negedge clk_i);
    check_flag("retire_valid_o", retire_valid_o, 1'b0);
    check_flag("empty_o", empty_o, 1'b1);
    check_flag("issue_ready_o", issue_ready_o, 1'b1);
    for (int i = 0; i < `REG_COUNT; i++) begin
        read_reg(regaddr_t'(i), regs_model[i]);
    end

    print_counts();
    if (value_errors == 0 && protocol_errors == 0) begin
        $display("Test completed successfully");
    end else begin
        $display("Test failed");
    end
    $finish;
end

endmodule

`default_nettype wire

// File: compile.f
+incdir+hdl
hdl/cpu_pkg.sv
hdl/cpu_ma.sv
hdl/cpu_dmem.sv
hdl/cpu_wb.sv
hdl/cpu_regfile.sv
hdl/cpu_mem_wb.sv
bench/cpu_mem_wb_tb.sv

// File: Makefile
# Verilator build and run of the memory-access and write-back testbench

VERILATOR ?= verilator
TOP       ?= cpu_mem_wb_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Test failed" $(LOG); then \
	    echo "simulation did not pass, see $(LOG)"; \
	    exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
